// ==== compile.f ====
+incdir+include
rtl/id_pkg.sv
rtl/instr_decoder.sv
rtl/operand_bypass.sv
rtl/pair_issue_check.sv
rtl/issue_regs.sv
rtl/decode_stage.sv
verif/decode_ref_model.sv
verif/tb_decode_stage.sv

// ==== include/id_config.svh ====
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

`define ID_XLEN     32
`define ID_RADDR_W  5
`define ID_ALU_OPS  9

// opcode fields of the instruction word
`define ID_OP6_HI   31
`define ID_OP6_LO   26
`define ID_OP4_HI   25
`define ID_OP4_LO   22
`define ID_OP2_HI   21
`define ID_OP2_LO   20
`define ID_OP5_HI   19
`define ID_OP5_LO   15

// bit positions in the one-hot alu_op
`define ID_ALU_ADD  0
`define ID_ALU_SUB  1
`define ID_ALU_SLT  2
`define ID_ALU_SLTU 3
`define ID_ALU_AND  4
`define ID_ALU_OR   5
`define ID_ALU_XOR  6
`define ID_ALU_MUL  7
`define ID_ALU_DIV  8

`endif

// ==== rtl/decode_stage.sv ====
`include "id_config.svh"

module decode_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        flush,
  input  logic                        exe_ready,
  input  id_pkg::fetch_slot_t         slot0,
  input  id_pkg::fetch_slot_t         slot1,
  input  logic                        slot0_valid,
  input  logic                        slot1_valid,
  input  id_pkg::bypass_t             bypass_a,
  input  id_pkg::bypass_t             bypass_b,
  output logic [3:0][`ID_RADDR_W-1:0] rf_raddr,
  input  logic [3:0][`ID_XLEN-1:0]    rf_rdata,
  output logic [1:0]                  pop,
  output id_pkg::issue_op_t           issue0,
  output id_pkg::issue_op_t           issue1,
  output logic                        issue0_valid,
  output logic                        issue1_valid
);
  import id_pkg::*;

  logic [3:0][`ID_XLEN-1:0] opnd;
  issue_op_t                dec_op0;
  issue_op_t                dec_op1;
  slot_class_t              cls0;
  slot_class_t              cls1;
  logic                     pair_ok;
  logic                     valid0;
  logic                     valid1;

  // ports 0,1 belong to slot0 and ports 2,3 to slot1
  instr_decoder u_dec0 (
    .slot      (slot0),
    .rf_raddr1 (rf_raddr[0]),
    .rf_raddr2 (rf_raddr[1]),
    .rj_value  (opnd[0]),
    .rkd_value (opnd[1]),
    .op        (dec_op0),
    .cls       (cls0)
  );

  instr_decoder u_dec1 (
    .slot      (slot1),
    .rf_raddr1 (rf_raddr[2]),
    .rf_raddr2 (rf_raddr[3]),
    .rj_value  (opnd[2]),
    .rkd_value (opnd[3]),
    .op        (dec_op1),
    .cls       (cls1)
  );

  for (genvar i = 0; i < 4; i++)
  begin : g_bypass
    operand_bypass u_byp (
      .raddr    (rf_raddr[i]),
      .rf_data  (rf_rdata[i]),
      .bypass_a (bypass_a),
      .bypass_b (bypass_b),
      .value    (opnd[i])
    );
  end

  pair_issue_check u_pair (
    .cls0    (cls0),
    .cls1    (cls1),
    .pair_ok (pair_ok)
  );

  assign valid0 = slot0_valid;
  assign valid1 = slot1_valid & pair_ok;

  // consumed from fetch only when execute takes them
  assign pop = {valid1, valid0} & {2{exe_ready}};

  issue_regs u_regs (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .exe_ready    (exe_ready),
    .in_op0       (dec_op0),
    .in_op1       (dec_op1),
    .in_valid0    (valid0),
    .in_valid1    (valid1),
    .issue0       (issue0),
    .issue1       (issue1),
    .issue0_valid (issue0_valid),
    .issue1_valid (issue1_valid)
  );

endmodule

// ==== rtl/id_pkg.sv ====
`include "id_config.svh"

package id_pkg;

  typedef struct packed {
    logic [`ID_XLEN-1:0] pc;
    logic [`ID_XLEN-1:0] instr;
  } fetch_slot_t;

  // result forwarded from a later stage
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`ID_RADDR_W-1:0] dest;
    logic [`ID_XLEN-1:0]    data;
  } bypass_t;

  // second alu operand
  typedef enum logic [1:0] {
    SRC2_RKD  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2
  } src_sel_t;

  typedef struct packed {
    logic [`ID_XLEN-1:0]    pc;
    logic [`ID_ALU_OPS-1:0] alu_op;
    logic [`ID_XLEN-1:0]    imm;
    logic [`ID_XLEN-1:0]    rj_value;
    logic [`ID_XLEN-1:0]    rkd_value;
    logic [`ID_RADDR_W-1:0] dest;
    src_sel_t               src2;
    logic                   src1_is_pc;
    logic                   gr_we;
    logic                   mem_we;
    logic                   res_from_mem;
    logic                   is_branch;
    logic                   branch_eq;
    logic                   branch_ne;
    logic                   is_link;
    logic                   illegal;
  } issue_op_t;

  // what the pairing check needs to know about one slot
  typedef struct packed {
    logic                   is_ls;
    logic                   is_mul;
    logic                   is_div;
    logic                   may_jump;
    logic                   illegal;
    logic                   gr_we;
    logic                   use_rj;
    logic                   use_rkd;
    logic [`ID_RADDR_W-1:0] dest;
    logic [`ID_RADDR_W-1:0] raddr1;
    logic [`ID_RADDR_W-1:0] raddr2;
  } slot_class_t;

endpackage

// ==== rtl/instr_decoder.sv ====
`include "id_config.svh"

module instr_decoder (
  input  id_pkg::fetch_slot_t     slot,
  output logic [`ID_RADDR_W-1:0]  rf_raddr1,
  output logic [`ID_RADDR_W-1:0]  rf_raddr2,
  input  logic [`ID_XLEN-1:0]     rj_value,
  input  logic [`ID_XLEN-1:0]     rkd_value,
  output id_pkg::issue_op_t       op,
  output id_pkg::slot_class_t     cls
);
  import id_pkg::*;

  logic [`ID_XLEN-1:0]    inst;
  logic [5:0]             op6;
  logic [3:0]             op4;
  logic [1:0]             op2;
  logic [4:0]             op5;
  logic [4:0]             rd;
  logic [4:0]             rj;
  logic [4:0]             rk;
  logic [11:0]            i12;
  logic [15:0]            i16;
  logic [25:0]            i26;

  logic                   grp_3r;
  logic                   inst_add_w;
  logic                   inst_sub_w;
  logic                   inst_slt;
  logic                   inst_sltu;
  logic                   inst_and;
  logic                   inst_or;
  logic                   inst_xor;
  logic                   inst_mul_w;
  logic                   inst_div_w;
  logic                   inst_addi_w;
  logic                   inst_andi;
  logic                   inst_ori;
  logic                   inst_ld_w;
  logic                   inst_st_w;
  logic                   inst_jirl;
  logic                   inst_b;
  logic                   inst_bl;
  logic                   inst_beq;
  logic                   inst_bne;

  logic                   legal;
  logic                   is_rr;
  logic                   may_jump;
  logic                   need_si12;
  logic                   need_ui12;
  logic                   need_si16;
  logic                   need_si26;
  logic                   gr_we;
  logic [`ID_RADDR_W-1:0] dest;
  logic [`ID_ALU_OPS-1:0] alu_op;
  logic [`ID_XLEN-1:0]    imm;
  src_sel_t               src2;

  assign inst = slot.instr;
  assign op6  = inst[`ID_OP6_HI:`ID_OP6_LO];
  assign op4  = inst[`ID_OP4_HI:`ID_OP4_LO];
  assign op2  = inst[`ID_OP2_HI:`ID_OP2_LO];
  assign op5  = inst[`ID_OP5_HI:`ID_OP5_LO];
  assign rd   = inst[4:0];
  assign rj   = inst[9:5];
  assign rk   = inst[14:10];
  assign i12  = inst[21:10];
  assign i16  = inst[25:10];
  assign i26  = {inst[9:0], inst[25:10]};

  // three-register group
  assign grp_3r     = (op6 == 6'h00) & (op4 == 4'h0) & (op2 == 2'h1);
  assign inst_add_w = grp_3r & (op5 == 5'h00);
  assign inst_sub_w = grp_3r & (op5 == 5'h02);
  assign inst_slt   = grp_3r & (op5 == 5'h04);
  assign inst_sltu  = grp_3r & (op5 == 5'h05);
  assign inst_and   = grp_3r & (op5 == 5'h09);
  assign inst_or    = grp_3r & (op5 == 5'h0a);
  assign inst_xor   = grp_3r & (op5 == 5'h0b);
  assign inst_mul_w = grp_3r & (op5 == 5'h18);
  assign inst_div_w = (op6 == 6'h00) & (op4 == 4'h0) & (op2 == 2'h2) & (op5 == 5'h00);

  assign inst_addi_w = (op6 == 6'h00) & (op4 == 4'ha);
  assign inst_andi   = (op6 == 6'h00) & (op4 == 4'hd);
  assign inst_ori    = (op6 == 6'h00) & (op4 == 4'he);
  assign inst_ld_w   = (op6 == 6'h0a) & (op4 == 4'h2);
  assign inst_st_w   = (op6 == 6'h0a) & (op4 == 4'h6);
  assign inst_jirl   = (op6 == 6'h13);
  assign inst_b      = (op6 == 6'h14);
  assign inst_bl     = (op6 == 6'h15);
  assign inst_beq    = (op6 == 6'h16);
  assign inst_bne    = (op6 == 6'h17);

  assign is_rr    = inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_and |
                    inst_or | inst_xor | inst_mul_w | inst_div_w;
  assign may_jump = inst_beq | inst_bne | inst_b | inst_bl | inst_jirl;
  assign legal    = is_rr | may_jump | inst_addi_w | inst_andi | inst_ori |
                    inst_ld_w | inst_st_w;

  assign alu_op[`ID_ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w |
                                inst_jirl | inst_bl;
  assign alu_op[`ID_ALU_SUB]  = inst_sub_w | inst_beq | inst_bne;
  assign alu_op[`ID_ALU_SLT]  = inst_slt;
  assign alu_op[`ID_ALU_SLTU] = inst_sltu;
  assign alu_op[`ID_ALU_AND]  = inst_and | inst_andi;
  assign alu_op[`ID_ALU_OR]   = inst_or | inst_ori;
  assign alu_op[`ID_ALU_XOR]  = inst_xor;
  assign alu_op[`ID_ALU_MUL]  = inst_mul_w;
  assign alu_op[`ID_ALU_DIV]  = inst_div_w;

  assign need_si12 = inst_addi_w | inst_ld_w | inst_st_w;
  assign need_ui12 = inst_andi | inst_ori;
  assign need_si16 = inst_beq | inst_bne | inst_jirl;
  assign need_si26 = inst_b | inst_bl;

  // branch offsets are word offsets
  always_comb
  begin
    if (need_si26)
      imm = {{4{i26[25]}}, i26, 2'b00};
    else if (need_si16)
      imm = {{14{i16[15]}}, i16, 2'b00};
    else if (need_ui12)
      imm = {20'b0, i12};
    else if (need_si12)
      imm = {{20{i12[11]}}, i12};
    else
      imm = '0;
  end

  always_comb
  begin
    if (inst_jirl | inst_bl)
      src2 = SRC2_FOUR;
    else if (need_si12 | need_ui12)
      src2 = SRC2_IMM;
    else
      src2 = SRC2_RKD;
  end

  assign dest  = inst_bl ? 5'd1 : rd;
  assign gr_we = legal & ~(inst_st_w | inst_beq | inst_bne | inst_b) & (dest != '0);

  // compares and stores read rd as the second source
  assign rf_raddr1 = rj;
  assign rf_raddr2 = (inst_beq | inst_bne | inst_st_w) ? rd : rk;

  always_comb
  begin
    op.pc           = slot.pc;
    op.alu_op       = alu_op;
    op.imm          = imm;
    op.rj_value     = rj_value;
    op.rkd_value    = rkd_value;
    op.dest         = dest;
    op.src2         = src2;
    op.src1_is_pc   = inst_jirl | inst_bl;
    op.gr_we        = gr_we;
    op.mem_we       = inst_st_w;
    op.res_from_mem = inst_ld_w;
    op.is_branch    = may_jump;
    op.branch_eq    = inst_beq;
    op.branch_ne    = inst_bne;
    op.is_link      = inst_jirl | inst_bl;
    op.illegal      = ~legal;
  end

  always_comb
  begin
    cls.is_ls    = inst_ld_w | inst_st_w;
    cls.is_mul   = inst_mul_w;
    cls.is_div   = inst_div_w;
    cls.may_jump = may_jump;
    cls.illegal  = ~legal;
    cls.gr_we    = gr_we;
    cls.use_rj   = ~(inst_b | inst_bl);
    cls.use_rkd  = is_rr | inst_beq | inst_bne | inst_st_w;
    cls.dest     = dest;
    cls.raddr1   = rf_raddr1;
    cls.raddr2   = rf_raddr2;
  end

  alu_op_onehot: assert final ($onehot0(alu_op))
    else $error("instr_decoder: alu_op %b has more than one bit set", alu_op);

endmodule

// ==== rtl/issue_regs.sv ====
module issue_regs (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush,
  input  logic              exe_ready,
  input  id_pkg::issue_op_t in_op0,
  input  id_pkg::issue_op_t in_op1,
  input  logic              in_valid0,
  input  logic              in_valid1,
  output id_pkg::issue_op_t issue0,
  output id_pkg::issue_op_t issue1,
  output logic              issue0_valid,
  output logic              issue1_valid
);

  // flush beats stall
  always_ff @(posedge clk)
  begin
    if (rst || flush)
    begin
      issue0_valid <= 1'b0;
      issue1_valid <= 1'b0;
    end
    else if (exe_ready)
    begin
      issue0_valid <= in_valid0;
      issue1_valid <= in_valid1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (exe_ready)
    begin
      issue0 <= in_op0;
      issue1 <= in_op1;
    end
  end

  valids_clear: assert property (@(posedge clk)
    (rst || flush) |=> !issue0_valid && !issue1_valid)
    else $error("issue_regs: valid left set after reset or flush");

  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    !exe_ready && !flush |=> $stable({issue0, issue1, issue0_valid, issue1_valid}))
    else $error("issue_regs: outputs changed during a stall");

endmodule

// ==== rtl/operand_bypass.sv ====
`include "id_config.svh"

module operand_bypass (
  input  logic [`ID_RADDR_W-1:0] raddr,
  input  logic [`ID_XLEN-1:0]    rf_data,
  input  id_pkg::bypass_t        bypass_a,
  input  id_pkg::bypass_t        bypass_b,
  output logic [`ID_XLEN-1:0]    value
);

  logic hit_a;
  logic hit_b;

  assign hit_a = bypass_a.valid & bypass_a.we & (bypass_a.dest == raddr);
  assign hit_b = bypass_b.valid & bypass_b.we & (bypass_b.dest == raddr);

  // bypass_b is the younger result
  always_comb
  begin
    if (hit_b)
      value = bypass_b.data;
    else if (hit_a)
      value = bypass_a.data;
    else
      value = rf_data;
  end

endmodule

// ==== rtl/pair_issue_check.sv ====
module pair_issue_check (
  input  id_pkg::slot_class_t cls0,
  input  id_pkg::slot_class_t cls1,
  output logic                pair_ok
);

  logic slot0_solo;
  logic unit_clash;
  logic order_clash;
  logic raw_hazard;

  // jumps and memory ops in slot0 issue alone
  assign slot0_solo = cls0.may_jump | cls0.is_ls | cls0.illegal;

  // one multiplier and one divider
  assign unit_clash = (cls0.is_mul & cls1.is_mul) | (cls0.is_div & cls1.is_div);

  // no jump or memory op behind a mul or div
  assign order_clash = (cls1.may_jump | cls1.is_ls) & (cls0.is_mul | cls0.is_div);

  // slot1 reads what slot0 writes
  assign raw_hazard = cls0.gr_we & (cls0.dest != '0) &
                      ((cls1.use_rj & (cls1.raddr1 == cls0.dest)) |
                       (cls1.use_rkd & (cls1.raddr2 == cls0.dest)));

  assign pair_ok = ~(slot0_solo | cls1.illegal | unit_clash | order_clash | raw_hazard);

endmodule

// ==== verif/decode_ref_model.sv ====
`include "id_config.svh"

module decode_ref_model (
  input  id_pkg::fetch_slot_t slot0,
  input  id_pkg::fetch_slot_t slot1,
  input  logic                slot0_valid,
  input  logic                slot1_valid,
  input  id_pkg::bypass_t     bypass_a,
  input  id_pkg::bypass_t     bypass_b,
  input  logic [31:0]         rf [32],
  output id_pkg::issue_op_t   exp_op0,
  output id_pkg::issue_op_t   exp_op1,
  output logic                exp_valid0,
  output logic                exp_valid1
);
  timeunit 1ns;
  timeprecision 1ps;
  import id_pkg::*;

  typedef enum int {
    M_ADD, M_SUB, M_SLT, M_SLTU, M_AND, M_OR, M_XOR, M_MUL, M_DIV,
    M_ADDI, M_ANDI, M_ORI, M_LDW, M_STW, M_JIRL, M_B, M_BL, M_BEQ, M_BNE, M_BAD
  } mnemonic_t;

  // fixed opcode bits, in mnemonic_t order
  localparam logic [31:0] OP_BASE [19] = '{
    32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000, 32'h0014_8000,
    32'h0015_0000, 32'h0015_8000, 32'h001c_0000, 32'h0020_0000, 32'h0280_0000,
    32'h0340_0000, 32'h0380_0000, 32'h2880_0000, 32'h2980_0000, 32'h4c00_0000,
    32'h5000_0000, 32'h5400_0000, 32'h5800_0000, 32'h5c00_0000
  };

  function automatic logic [31:0] op_base(input int k);
    return OP_BASE[k];
  endfunction

  function automatic logic [31:0] op_mask(input int k);
    if (k <= M_DIV)
      return 32'hffff_8000;
    else if (k <= M_STW)
      return 32'hffc0_0000;
    else
      return 32'hfc00_0000;
  endfunction

  function automatic int mnemonic(input logic [31:0] w);
    int m;
    m = M_BAD;
    for (int k = 0; k < M_BAD; k++)
      if ((w & op_mask(k)) == op_base(k))
        m = k;
    return m;
  endfunction

  function automatic logic [4:0] second_addr(input logic [31:0] w);
    int m;
    m = mnemonic(w);
    return (m == M_BEQ || m == M_BNE || m == M_STW) ? w[4:0] : w[14:10];
  endfunction

  // younger bypass first, then older, then register file
  function automatic logic [31:0] operand(input logic [4:0] addr);
    if (bypass_b.valid && bypass_b.we && bypass_b.dest == addr)
      return bypass_b.data;
    else if (bypass_a.valid && bypass_a.we && bypass_a.dest == addr)
      return bypass_a.data;
    else
      return rf[addr];
  endfunction

  function automatic issue_op_t decode(input fetch_slot_t s);
    issue_op_t   o;
    int          m;
    logic [31:0] w;
    w = s.instr;
    m = mnemonic(w);
    o = '0;
    o.pc = s.pc;
    o.illegal = (m == M_BAD);
    o.dest = (m == M_BL) ? 5'd1 : w[4:0];
    o.rj_value = operand(w[9:5]);
    o.rkd_value = operand(second_addr(w));
    case (m)
      M_ADD, M_ADDI, M_LDW, M_STW, M_JIRL, M_BL: o.alu_op[`ID_ALU_ADD] = 1'b1;
      M_SUB, M_BEQ, M_BNE: o.alu_op[`ID_ALU_SUB] = 1'b1;
      M_SLT: o.alu_op[`ID_ALU_SLT] = 1'b1;
      M_SLTU: o.alu_op[`ID_ALU_SLTU] = 1'b1;
      M_AND, M_ANDI: o.alu_op[`ID_ALU_AND] = 1'b1;
      M_OR, M_ORI: o.alu_op[`ID_ALU_OR] = 1'b1;
      M_XOR: o.alu_op[`ID_ALU_XOR] = 1'b1;
      M_MUL: o.alu_op[`ID_ALU_MUL] = 1'b1;
      M_DIV: o.alu_op[`ID_ALU_DIV] = 1'b1;
      default: ;
    endcase
    case (m)
      M_ADDI, M_LDW, M_STW: o.imm = {{20{w[21]}}, w[21:10]};
      M_ANDI, M_ORI: o.imm = {20'b0, w[21:10]};
      M_BEQ, M_BNE, M_JIRL: o.imm = {{14{w[25]}}, w[25:10], 2'b00};
      M_B, M_BL: o.imm = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
      default: ;
    endcase
    o.src1_is_pc = (m == M_JIRL) || (m == M_BL);
    o.is_link = o.src1_is_pc;
    if (o.is_link)
      o.src2 = SRC2_FOUR;
    else if (m >= M_ADDI && m <= M_STW)
      o.src2 = SRC2_IMM;
    o.mem_we = (m == M_STW);
    o.res_from_mem = (m == M_LDW);
    o.is_branch = (m >= M_JIRL) && (m <= M_BNE);
    o.branch_eq = (m == M_BEQ);
    o.branch_ne = (m == M_BNE);
    o.gr_we = !o.illegal && !o.mem_we && !o.branch_eq && !o.branch_ne &&
              (m != M_B) && (o.dest != 5'd0);
    return o;
  endfunction

  function automatic logic pair_allowed(input logic [31:0] w1, input issue_op_t o0,
                                        input int m0);
    int   m1;
    logic reads_rj;
    logic reads_rkd;
    m1 = mnemonic(w1);
    if (o0.is_branch || o0.mem_we || o0.res_from_mem || o0.illegal || m1 == M_BAD)
      return 1'b0;
    if (m0 == m1 && (m0 == M_MUL || m0 == M_DIV))
      return 1'b0;
    // everything from ld.w up is a memory op or a jump
    if ((m0 == M_MUL || m0 == M_DIV) && m1 >= M_LDW)
      return 1'b0;
    reads_rj = (m1 != M_B) && (m1 != M_BL) && (w1[9:5] == o0.dest);
    reads_rkd = (m1 <= M_DIV || m1 == M_BEQ || m1 == M_BNE || m1 == M_STW) &&
                (second_addr(w1) == o0.dest);
    return !(o0.gr_we && (reads_rj || reads_rkd));
  endfunction

  always_comb
  begin
    exp_op0 = decode(slot0);
    exp_op1 = decode(slot1);
    exp_valid0 = slot0_valid;
    exp_valid1 = slot1_valid && pair_allowed(slot1.instr, exp_op0, mnemonic(slot0.instr));
  end

endmodule

// ==== verif/tb_decode_stage.sv ====
`include "id_config.svh"

module tb_decode_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import id_pkg::*;

  localparam int N_TESTS  = 5;
  localparam int N_CYCLES = 400;

  logic                              clk = 1'b0;
  logic                              rst;
  logic                              flush;
  logic                              exe_ready;
  fetch_slot_t                       slot0;
  fetch_slot_t                       slot1;
  logic                              slot0_valid;
  logic                              slot1_valid;
  bypass_t                           bypass_a;
  bypass_t                           bypass_b;
  logic [3:0][`ID_RADDR_W-1:0]       rf_raddr;
  logic [3:0][`ID_XLEN-1:0]          rf_rdata;
  logic [1:0]                        pop;
  issue_op_t                         issue0;
  issue_op_t                         issue1;
  logic                              issue0_valid;
  logic                              issue1_valid;

  logic [31:0]                       rf [32];
  issue_op_t                         exp_op0;
  issue_op_t                         exp_op1;
  logic                              exp_valid0;
  logic                              exp_valid1;

  // expected contents of the stage register
  issue_op_t                         q_op0;
  issue_op_t                         q_op1;
  logic                              q_valid0;
  logic                              q_valid1;

  logic [31:0]                       lcg_state;
  int                                errors;
  int                                test_errors;

  decode_stage u_dut (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .exe_ready    (exe_ready),
    .slot0        (slot0),
    .slot1        (slot1),
    .slot0_valid  (slot0_valid),
    .slot1_valid  (slot1_valid),
    .bypass_a     (bypass_a),
    .bypass_b     (bypass_b),
    .rf_raddr     (rf_raddr),
    .rf_rdata     (rf_rdata),
    .pop          (pop),
    .issue0       (issue0),
    .issue1       (issue1),
    .issue0_valid (issue0_valid),
    .issue1_valid (issue1_valid)
  );

  decode_ref_model u_model (
    .slot0       (slot0),
    .slot1       (slot1),
    .slot0_valid (slot0_valid),
    .slot1_valid (slot1_valid),
    .bypass_a    (bypass_a),
    .bypass_b    (bypass_b),
    .rf          (rf),
    .exp_op0     (exp_op0),
    .exp_op1     (exp_op1),
    .exp_valid0  (exp_valid0),
    .exp_valid1  (exp_valid1)
  );

  always #5 clk = ~clk;

  // register file read ports, same cycle
  always_comb
  begin
    for (int i = 0; i < 4; i++)
      rf_rdata[i] = rf[rf_raddr[i]];
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int pick(input int n);
    logic [31:0] r;
    r = next_random();
    return int'(r[31:16]) % n;
  endfunction

  // few registers so that hazards come up often
  function automatic logic [4:0] small_reg();
    return 5'(pick(6));
  endfunction

  function automatic logic [31:0] random_instr();
    int          k;
    logic [31:0] w;
    if (pick(10) == 0)
      return next_random();
    k = pick(19);
    w = u_model.op_base(k) | (next_random() & ~u_model.op_mask(k));
    // b and bl keep offset bits in 9:0
    if (k != 15 && k != 16)
      w[9:0] = {small_reg(), small_reg()};
    if (k <= 8)
      w[14:10] = small_reg();
    return w;
  endfunction

  function automatic bypass_t random_bypass(input logic enable);
    bypass_t b;
    b.valid = enable && (pick(4) != 0);
    b.we = (pick(4) != 0);
    b.dest = small_reg();
    b.data = next_random();
    return b;
  endfunction

  function automatic string test_name(input int test);
    case (test)
      1: return "decode fields";
      2: return "bypass priority";
      3: return "pairing";
      4: return "stall";
      default: return "flush and reset";
    endcase
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR %0t ns: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic drive_inputs(input int test);
    slot0.instr = random_instr();
    slot0.pc = next_random() & 32'hffff_fffc;
    slot1.instr = random_instr();
    slot1.pc = slot0.pc + 32'd4;
    slot0_valid = (test <= 3) || (pick(8) != 0);
    slot1_valid = (test == 3) || (test != 1 && pick(2) == 1);
    bypass_a = random_bypass(test >= 2);
    bypass_b = random_bypass(test >= 2);
    exe_ready = (test < 4) || (pick(3) != 0);
    flush = (test == 5) && (pick(8) == 0);
    rst = (test == 5) && (pick(60) == 0);
    rf[1 + pick(31)] = next_random();
  endtask

  task automatic run_cycle();
    logic [3:0][`ID_RADDR_W-1:0] exp_raddr;
    @(posedge clk);
    if (exe_ready)
    begin
      q_op0 = exp_op0;
      q_op1 = exp_op1;
    end
    if (rst || flush)
    begin
      q_valid0 = 1'b0;
      q_valid1 = 1'b0;
    end
    else if (exe_ready)
    begin
      q_valid0 = exp_valid0;
      q_valid1 = exp_valid1;
    end
    @(negedge clk);
    // rj first, then rd or rk, slot0 on ports 0 and 1
    exp_raddr = {u_model.second_addr(slot1.instr), slot1.instr[9:5],
                 u_model.second_addr(slot0.instr), slot0.instr[9:5]};
    if (rf_raddr !== exp_raddr)
      report_error($sformatf("rf_raddr %h, expected %h", rf_raddr, exp_raddr));
    if (issue0_valid !== q_valid0)
      report_error($sformatf("issue0_valid %b, expected %b", issue0_valid, q_valid0));
    if (issue1_valid !== q_valid1)
      report_error($sformatf("issue1_valid %b, expected %b", issue1_valid, q_valid1));
    if (q_valid0 && issue0 !== q_op0)
      report_error($sformatf("issue0 %h, expected %h", issue0, q_op0));
    if (q_valid1 && issue1 !== q_op1)
      report_error($sformatf("issue1 %h, expected %h", issue1, q_op1));
    if (pop !== ({exp_valid1, exp_valid0} & {2{exe_ready}}))
      report_error($sformatf("pop %b, expected %b", pop,
                             {exp_valid1, exp_valid0} & {2{exe_ready}}));
  endtask

  initial
  begin
    lcg_state = 32'd1301;
    errors = 0;
    test_errors = 0;
    for (int i = 0; i < 32; i++)
      rf[i] = (i == 0) ? 32'd0 : next_random();
    rst = 1'b1;
    flush = 1'b0;
    exe_ready = 1'b1;
    slot0 = '0;
    slot1 = '0;
    slot0_valid = 1'b0;
    slot1_valid = 1'b0;
    bypass_a = '0;
    bypass_b = '0;
    q_op0 = '0;
    q_op1 = '0;
    q_valid0 = 1'b0;
    q_valid1 = 1'b0;
    repeat (4) run_cycle();
    rst = 1'b0;
    for (int t = 1; t <= N_TESTS; t++)
    begin
      test_errors = 0;
      for (int c = 0; c < N_CYCLES; c++)
      begin
        drive_inputs(t);
        run_cycle();
      end
      $display("test %0d %s: %0d cycles, %0d errors", t, test_name(t), N_CYCLES, test_errors);
    end
    $display("tests %0d, cycles %0d, errors %0d", N_TESTS, N_TESTS * N_CYCLES, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // all test cycles plus reset and some slack
  initial
  begin
    #((N_TESTS * N_CYCLES + 4 + 50) * 10);
    $display("watchdog: the run did not finish in the expected time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
